// File: hdl/common.sv
package common;

    // Bus widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0] data_t;

    typedef enum logic [2:0] {
        MACHINE_48 = 3'd0,
        MACHINE_128 = 3'd1,
        MACHINE_PENT = 3'd2
    } machine_t;

    typedef enum logic [2:0] {
        TURBO_NONE = 3'd0,
        TURBO_X2 = 3'd1,
        TURBO_X4 = 3'd2,
        TURBO_X8 = 3'd3
    } turbo_t;

    typedef enum logic [1:0] {
        PANNING_ABC = 2'd0,
        PANNING_ACB = 2'd1,
        PANNING_MONO = 2'd2
    } panning_t;

    typedef enum logic [1:0] {
        ROM_BASIC = 2'd0,
        ROM_MAGIC = 2'd1,
        ROM_DIVMMC = 2'd2
    } rom_bank_t;

    // Frame lengths in T-states
    localparam logic [16:0] FRAME_48 = 17'd69888;
    localparam logic [16:0] FRAME_128 = 17'd70908;
    localparam logic [16:0] FRAME_PENT = 17'd71680;

    localparam logic [16:0] INT_LEN = 17'd32;  // Interrupt pulse in T-states

endpackage

// File: hdl/cpu_bus_sync.sv
`timescale 1ns/1ns

module cpu_bus_sync (
    input logic clk28,
    input logic rst_n,
    input logic n_mreq,
    input logic n_iorq,
    input logic n_rd,
    input logic n_wr,
    input logic n_m1,
    input common::addr_t a,
    input common::data_t d,
    output logic memreq,
    output logic ioreq,
    output logic rd,
    output logic wr,
    output logic m1,
    output common::addr_t a_reg,
    output common::data_t d_reg
);

    // Strobes become active high here
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            memreq <= 1'b0;
            ioreq <= 1'b0;
            rd <= 1'b0;
            wr <= 1'b0;
            m1 <= 1'b0;
        end else begin
            memreq <= !n_mreq;
            ioreq <= !n_iorq;
            rd <= !n_rd;
            wr <= !n_wr;
            m1 <= !n_m1;
        end
    end

    always_ff @(posedge clk28) begin
        a_reg <= a;
        d_reg <= d;  // Only meaningful during writes
    end

endmodule

// File: hdl/frame_int.sv
`timescale 1ns/1ns

module frame_int #(
    parameter int CLK_DIV = 8
) (
    input logic clk28,
    input logic rst_n,
    input common::machine_t machine,
    output logic n_int,
    output logic n_int_next
);
    import common::*;

    localparam int PRE_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [PRE_W-1:0] pre_cnt;
    logic t_tick;
    logic [16:0] frame_len;
    logic [16:0] t_cnt;
    logic [16:0] t_cnt_next;

    assign t_tick = (pre_cnt == PRE_W'(CLK_DIV - 1));  // One pulse per T-state

    always_comb begin
        case (machine)
            MACHINE_48: frame_len = FRAME_48;
            MACHINE_128: frame_len = FRAME_128;
            default: frame_len = FRAME_PENT;
        endcase
    end

    // Wrap also covers a switch to a shorter frame mid-count
    always_comb begin
        t_cnt_next = t_cnt;
        if (t_tick) begin
            if (t_cnt >= frame_len - 17'd1)
                t_cnt_next = '0;
            else
                t_cnt_next = t_cnt + 17'd1;
        end
    end

    assign n_int_next = (t_cnt_next >= INT_LEN);

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            t_cnt <= INT_LEN;  // Start just past the pulse
            n_int <= 1'b1;
        end else begin
            if (t_tick)
                pre_cnt <= '0;
            else
                pre_cnt <= pre_cnt + 1'b1;
            t_cnt <= t_cnt_next;
            n_int <= n_int_next;
        end
    end

endmodule

// File: hdl/magic.sv
`timescale 1ns/1ns

module magic (
    input logic clk28,
    input logic rst_n,
    input logic memreq,
    input logic ioreq,
    input logic rd,
    input logic wr,
    input logic m1,
    input common::addr_t a_reg,
    input common::data_t d_reg,
    input logic n_int,
    input logic n_int_next,
    input logic magic_button,
    input logic pause_button,
    input logic div_automap,
    output logic n_nmi,
    output logic magic_map,
    output common::data_t d_out,
    output logic d_out_active,
    output logic magic_reboot,
    output logic magic_beeper,
    output common::machine_t machine,
    output common::turbo_t turbo,
    output common::panning_t panning,
    output logic joy_sinclair,
    output logic divmmc_en,
    output logic zc_en,
    output logic ulaplus_en,
    output logic ay_en,
    output logic covox_en,
    output logic soundrive_en
);
    import common::*;

    typedef enum logic [2:0] {
        MAP_ON,
        MAP_EXIT,
        MAP_TEMP_EXIT,
        MAP_OFF,
        MAP_TEMP_OFF
    } map_state_t;

    map_state_t map_state;
    map_state_t map_state_next;
    logic magic_mode;
    logic mapped;
    logic rd_f000;
    logic rd_f008;
    logic entry_fetch;
    logic frame_edge;
    logic config_cs;
    logic config_rd;

    assign mapped = (map_state == MAP_ON) || (map_state == MAP_EXIT) ||
                    (map_state == MAP_TEMP_EXIT);
    assign rd_f000 = (map_state == MAP_ON || map_state == MAP_EXIT) &&
                     memreq && rd && (a_reg == 16'hF000);
    assign rd_f008 = mapped && memreq && rd && (a_reg == 16'hF008);
    assign entry_fetch = magic_mode && m1 && memreq &&
                         (a_reg == 16'h0066 || map_state == MAP_TEMP_OFF);
    assign frame_edge = n_int && !n_int_next;  // Interrupt about to start

    // Unmap waits for the end of the current memory cycle
    always_comb begin
        map_state_next = map_state;
        case (map_state)
            MAP_ON, MAP_EXIT: begin
                if (rd_f000)
                    map_state_next = MAP_EXIT;
                else if (rd_f008)
                    map_state_next = MAP_TEMP_EXIT;
                else if (map_state == MAP_EXIT && !memreq)
                    map_state_next = MAP_OFF;
            end
            MAP_TEMP_EXIT: begin
                if (!memreq)
                    map_state_next = MAP_TEMP_OFF;
            end
            default: begin
                if (entry_fetch)
                    map_state_next = MAP_ON;
            end
        endcase
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            map_state <= MAP_ON;
            magic_mode <= 1'b1;
            n_nmi <= 1'b1;
        end else begin
            map_state <= map_state_next;
            if (entry_fetch)
                n_nmi <= 1'b1;
            else if ((magic_button || pause_button) && frame_edge && !magic_mode)
                n_nmi <= 1'b0;
            if (rd_f000)
                magic_mode <= 1'b0;
            else if ((magic_button || pause_button) && frame_edge)
                magic_mode <= 1'b1;
        end
    end

    // ROM select is timing critical, so the entry fetch maps at once
    assign magic_map = mapped || entry_fetch;

    assign config_cs = magic_map && ioreq && (a_reg[7:0] == 8'hFF);

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            magic_reboot <= 1'b0;
            magic_beeper <= 1'b0;
            machine <= MACHINE_PENT;
            turbo <= TURBO_NONE;
            panning <= PANNING_ABC;
            joy_sinclair <= 1'b0;
            divmmc_en <= 1'b0;
            zc_en <= 1'b1;
            ulaplus_en <= 1'b1;
            ay_en <= 1'b1;
            covox_en <= 1'b1;
            soundrive_en <= 1'b1;
        end else if (config_cs && wr) begin
            case (a_reg[15:8])  // Register number in the high byte
                8'h01: {magic_reboot, magic_beeper} <= d_reg[1:0];
                8'h02: machine <= machine_t'(d_reg[2:0]);
                8'h03: turbo <= turbo_t'(d_reg[2:0]);
                8'h04: panning <= panning_t'(d_reg[1:0]);
                8'h07: joy_sinclair <= d_reg[0];
                8'h08: ay_en <= d_reg[0];
                8'h09: {zc_en, divmmc_en} <= d_reg[1:0];
                8'h0A: ulaplus_en <= d_reg[0];
                8'h0B: {soundrive_en, covox_en} <= d_reg[1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            config_rd <= 1'b0;
        else
            config_rd <= config_cs && rd && (a_reg[15:8] == 8'h00);
    end

    assign d_out = {4'b0000, div_automap, 1'b1, pause_button, magic_button};  // Status
    assign d_out_active = config_rd;

endmodule

// File: hdl/rom_map.sv
`timescale 1ns/1ns

module rom_map (
    input logic clk28,
    input logic rst_n,
    input logic memreq,
    input common::addr_t a_reg,
    input logic magic_map,
    input logic div_automap,
    input logic divmmc_en,
    output common::rom_bank_t rom_bank
);
    import common::*;

    logic memreq_d;
    logic cycle_start;
    rom_bank_t bank_sel;

    assign cycle_start = memreq && !memreq_d;

    always_comb begin
        if (magic_map)
            bank_sel = ROM_MAGIC;
        else if (divmmc_en && div_automap && a_reg[15:14] == 2'b00)
            bank_sel = ROM_DIVMMC;  // Lowest 16K only
        else
            bank_sel = ROM_BASIC;
    end

    // Bank stays fixed for the whole cycle
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            memreq_d <= 1'b0;
            rom_bank <= ROM_MAGIC;
        end else begin
            memreq_d <= memreq;
            if (cycle_start)
                rom_bank <= bank_sel;
        end
    end

endmodule

// File: hdl/zx_magic_top.sv
`timescale 1ns/1ns

module zx_magic_top #(
    parameter int CLK_DIV = 8
) (
    input logic clk28,
    input logic rst_n,
    input logic n_mreq,
    input logic n_iorq,
    input logic n_rd,
    input logic n_wr,
    input logic n_m1,
    input common::addr_t a,
    input common::data_t d,
    input logic magic_button,
    input logic pause_button,
    input logic div_automap,
    output logic n_nmi,
    output logic n_int,
    output common::rom_bank_t rom_bank,
    output common::data_t d_out,
    output logic d_out_active,
    output logic magic_reboot,
    output logic magic_beeper,
    output common::machine_t machine,
    output common::turbo_t turbo,
    output common::panning_t panning,
    output logic joy_sinclair,
    output logic divmmc_en,
    output logic zc_en,
    output logic ulaplus_en,
    output logic ay_en,
    output logic covox_en,
    output logic soundrive_en
);

    logic memreq;
    logic ioreq;
    logic rd;
    logic wr;
    logic m1;
    common::addr_t a_reg;
    common::data_t d_reg;
    logic n_int_next;
    logic magic_map;

    cpu_bus_sync u_cpu_bus_sync (
        .clk28(clk28), .rst_n(rst_n),
        .n_mreq(n_mreq), .n_iorq(n_iorq), .n_rd(n_rd), .n_wr(n_wr), .n_m1(n_m1),
        .a(a), .d(d),
        .memreq(memreq), .ioreq(ioreq), .rd(rd), .wr(wr), .m1(m1),
        .a_reg(a_reg), .d_reg(d_reg)
    );

    frame_int #(.CLK_DIV(CLK_DIV)) u_frame_int (
        .clk28(clk28), .rst_n(rst_n), .machine(machine),
        .n_int(n_int), .n_int_next(n_int_next)
    );

    magic u_magic (
        .clk28(clk28), .rst_n(rst_n),
        .memreq(memreq), .ioreq(ioreq), .rd(rd), .wr(wr), .m1(m1),
        .a_reg(a_reg), .d_reg(d_reg),
        .n_int(n_int), .n_int_next(n_int_next),
        .magic_button(magic_button), .pause_button(pause_button),
        .div_automap(div_automap),
        .n_nmi(n_nmi), .magic_map(magic_map),
        .d_out(d_out), .d_out_active(d_out_active),
        .magic_reboot(magic_reboot), .magic_beeper(magic_beeper),
        .machine(machine), .turbo(turbo), .panning(panning),
        .joy_sinclair(joy_sinclair), .divmmc_en(divmmc_en), .zc_en(zc_en),
        .ulaplus_en(ulaplus_en), .ay_en(ay_en), .covox_en(covox_en),
        .soundrive_en(soundrive_en)
    );

    rom_map u_rom_map (
        .clk28(clk28), .rst_n(rst_n),
        .memreq(memreq), .a_reg(a_reg),
        .magic_map(magic_map), .div_automap(div_automap), .divmmc_en(divmmc_en),
        .rom_bank(rom_bank)
    );

endmodule

// File: testbench/tb_zx_magic_top.sv
`timescale 1ns/1ns

module tb_zx_magic_top;
    import common::*;

    localparam int FRAME_WAIT = 150000;  // Two of the longest frames at CLK_DIV 1

    logic clk28, rst_n;
    logic n_mreq, n_iorq, n_rd, n_wr, n_m1;
    addr_t a;
    data_t d;
    logic magic_button, pause_button, div_automap;
    logic n_nmi, n_int, d_out_active, magic_reboot, magic_beeper;
    rom_bank_t rom_bank;
    data_t d_out;
    machine_t machine;
    turbo_t turbo;
    panning_t panning;
    logic joy_sinclair, divmmc_en, zc_en, ulaplus_en, ay_en, covox_en, soundrive_en;
    logic [31:0] lfsr_state;

    zx_magic_top #(.CLK_DIV(1)) u_zx_magic_top (.*);

    initial begin
        clk28 = 1'b0;
        forever #5 clk28 = ~clk28;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    function automatic data_t random_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
        end
        return v;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_bank(input rom_bank_t got, input rom_bank_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR rom_bank got 0x%0h expected 0x%0h", got, exp));
    endtask

    task automatic check_machine(input machine_t got, input machine_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR machine got 0x%0h expected 0x%0h", got, exp));
    endtask

    task automatic check_turbo(input turbo_t got, input turbo_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR turbo got 0x%0h expected 0x%0h", got, exp));
    endtask

    task automatic check_panning(input panning_t got, input panning_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR panning got 0x%0h expected 0x%0h", got, exp));
    endtask

    // Strobes held 3 clocks and released 2 with outputs sampled on falling edges
    task automatic bus_cycle(input logic is_mem, input logic is_m1, input logic is_wr,
                             input addr_t addr, input data_t data,
                             output logic seen_active, output data_t seen_data);
        seen_active = 1'b0;
        seen_data = '0;
        @(posedge clk28);
        a <= addr;
        d <= data;
        n_mreq <= !is_mem;
        n_iorq <= is_mem;
        n_rd <= is_wr;
        n_wr <= !is_wr;
        n_m1 <= !is_m1;
        for (int i = 1; i <= 5; i++) begin
            @(posedge clk28);
            if (i == 3) begin
                {n_mreq, n_iorq, n_rd, n_wr, n_m1} <= 5'b11111;
            end
            @(negedge clk28);
            if (d_out_active) begin
                seen_active = 1'b1;
                seen_data = d_out;
            end
        end
    endtask

    task automatic mem_read(input addr_t addr);
        logic act;
        data_t dat;
        bus_cycle(1'b1, 1'b0, 1'b0, addr, 8'h00, act, dat);
    endtask

    task automatic mem_write(input addr_t addr, input data_t data);
        logic act;
        data_t dat;
        bus_cycle(1'b1, 1'b0, 1'b1, addr, data, act, dat);
    endtask

    task automatic m1_fetch(input addr_t addr);
        logic act;
        data_t dat;
        bus_cycle(1'b1, 1'b1, 1'b0, addr, 8'h00, act, dat);
    endtask

    task automatic io_read(input addr_t addr, output logic act, output data_t dat);
        bus_cycle(1'b0, 1'b0, 1'b0, addr, 8'h00, act, dat);
    endtask

    task automatic io_write(input addr_t addr, input data_t data);
        logic act;
        data_t dat;
        bus_cycle(1'b0, 1'b0, 1'b1, addr, data, act, dat);
    endtask

    task automatic wait_n_int(input logic level);
        int n;
        n = 0;
        while (n_int !== level) begin
            @(negedge clk28);
            n++;
            if (n > FRAME_WAIT)
                stop_run($sformatf("n_int never went to %0d within a frame", level));
        end
    endtask

    task automatic wait_nmi_low();
        int n;
        n = 0;
        while (n_nmi !== 1'b0) begin
            @(negedge clk28);
            n++;
            if (n > FRAME_WAIT)
                stop_run("n_nmi never fell after the magic button was pressed");
        end
    endtask

    task automatic enter_magic();
        @(posedge clk28);
        magic_button <= 1'b1;
        wait_nmi_low();
        check_bit("n_int", n_int, 1'b0);  // Same edge as the frame interrupt
        @(posedge clk28);
        magic_button <= 1'b0;
        m1_fetch(16'h0066);
        check_bit("n_nmi", n_nmi, 1'b1);
        check_bank(rom_bank, ROM_MAGIC);
    endtask

    task automatic write_config(input data_t v1, v2, v3, v4, v7, v8, v9, va, vb);
        io_write(16'h01FF, v1);
        io_write(16'h02FF, v2);
        io_write(16'h03FF, v3);
        io_write(16'h04FF, v4);
        io_write(16'h07FF, v7);
        io_write(16'h08FF, v8);
        io_write(16'h09FF, v9);
        io_write(16'h0AFF, va);
        io_write(16'h0BFF, vb);
    endtask

    task automatic expect_config(input data_t v1, v2, v3, v4, v7, v8, v9, va, vb);
        check_bit("magic_reboot", magic_reboot, v1[1]);
        check_bit("magic_beeper", magic_beeper, v1[0]);
        check_machine(machine, machine_t'(v2[2:0]));
        check_turbo(turbo, turbo_t'(v3[2:0]));
        check_panning(panning, panning_t'(v4[1:0]));
        check_bit("joy_sinclair", joy_sinclair, v7[0]);
        check_bit("ay_en", ay_en, v8[0]);
        check_bit("zc_en", zc_en, v9[1]);
        check_bit("divmmc_en", divmmc_en, v9[0]);
        check_bit("ulaplus_en", ulaplus_en, va[0]);
        check_bit("soundrive_en", soundrive_en, vb[1]);
        check_bit("covox_en", covox_en, vb[0]);
    endtask

    task automatic test_reset_defaults();
        check_bit("n_nmi", n_nmi, 1'b1);
        check_bit("n_int", n_int, 1'b1);
        check_bit("d_out_active", d_out_active, 1'b0);
        // Pentagon with all sound on
        expect_config(8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h01, 8'h02, 8'h01, 8'h03);
        mem_read(16'h0000);
        check_bank(rom_bank, ROM_MAGIC);
    endtask

    task automatic test_exit_reentry();
        mem_read(16'hF000);
        mem_read(16'h8000);
        check_bank(rom_bank, ROM_BASIC);
        enter_magic();
        @(posedge clk28);
        magic_button <= 1'b1;  // Second press while still in magic mode
        wait_n_int(1'b1);
        wait_n_int(1'b0);
        repeat (4) @(negedge clk28);
        check_bit("n_nmi", n_nmi, 1'b1);
        @(posedge clk28);
        magic_button <= 1'b0;
    endtask

    task automatic test_config();
        data_t v1, v2, v3, v4, v7, v8, v9, va, vb;
        v1 = random_bits(8);
        v2 = random_bits(8);
        v3 = random_bits(8);
        v4 = random_bits(8);
        v7 = random_bits(8);
        v8 = random_bits(8);
        v9 = random_bits(8);
        va = random_bits(8);
        vb = random_bits(8);
        write_config(v1, v2, v3, v4, v7, v8, v9, va, vb);
        expect_config(v1, v2, v3, v4, v7, v8, v9, va, vb);
        mem_write(16'hF000, 8'h00);  // Writes never leave magic mode
        mem_read(16'h8000);
        check_bank(rom_bank, ROM_MAGIC);
        mem_read(16'hF000);
        write_config(~v1, ~v2, ~v3, ~v4, ~v7, ~v8, ~v9, ~va, ~vb);
        expect_config(v1, v2, v3, v4, v7, v8, v9, va, vb);
    endtask

    task automatic test_status();
        logic act;
        data_t dat;
        enter_magic();
        for (int k = 0; k < 8; k++) begin
            @(posedge clk28);
            magic_button <= k[0];
            pause_button <= k[1];
            div_automap <= k[2];
            io_read(16'h00FF, act, dat);
            check_bit("d_out_active", act, 1'b1);
            check_data("d_out", dat, {4'b0000, k[2], 1'b1, k[1], k[0]});
        end
        @(posedge clk28);
        {magic_button, pause_button, div_automap} <= 3'b000;
        mem_read(16'hF000);
        io_read(16'h00FF, act, dat);
        check_bit("d_out_active", act, 1'b0);
    endtask

    task automatic test_temp_unmap();
        enter_magic();
        io_write(16'h09FF, 8'h03);
        check_bit("divmmc_en", divmmc_en, 1'b1);
        mem_read(16'hF008);
        mem_read(16'h8000);
        check_bank(rom_bank, ROM_BASIC);
        m1_fetch(16'h1234);  // Any fetch maps again
        check_bank(rom_bank, ROM_MAGIC);
        mem_read(16'hF008);
        @(posedge clk28);
        div_automap <= 1'b1;
        mem_read(16'h0100);
        check_bank(rom_bank, ROM_DIVMMC);
        mem_read(16'h8000);
        check_bank(rom_bank, ROM_BASIC);
        @(posedge clk28);
        div_automap <= 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        {n_mreq, n_iorq, n_rd, n_wr, n_m1} = 5'b11111;
        a = '0;
        d = '0;
        {magic_button, pause_button, div_automap} = 3'b000;
        lfsr_state = 32'd74384;
        repeat (3) @(posedge clk28);
        rst_n <= 1'b1;
        @(negedge clk28);
        test_reset_defaults();
        test_exit_reentry();
        test_config();
        test_status();
        test_temp_unmap();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: zx_magic_top.f
hdl/common.sv
hdl/cpu_bus_sync.sv
hdl/frame_int.sv
hdl/magic.sv
hdl/rom_map.sv
hdl/zx_magic_top.sv
testbench/tb_zx_magic_top.sv
